//--- src/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] inst_t;
  typedef logic [1:0]      mem_size_t;

  localparam mem_size_t SIZE_BYTE = 2'd0;
  localparam mem_size_t SIZE_HALF = 2'd1;
  localparam mem_size_t SIZE_WORD = 2'd2;

  localparam addr_t RESET_PC = 32'h8000_0000; // start of dram

  // fetched instruction handed to decode
  typedef struct packed {
    addr_t pc;
    inst_t inst;
    logic  fault;
  } fetch_t;

  typedef struct packed {
    addr_t     addr;
    word_t     wdata;     // low bits hold the store value
    mem_size_t size;
    logic      is_signed;
    logic      wen;       // 1 = store
  } lsu_req_t;

  typedef struct packed {
    word_t rdata;
    logic  err;
  } lsu_resp_t;

endpackage

`default_nettype wire

//--- src/axi_pkg.sv
`default_nettype none

package axi_pkg;

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [1:0]            axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  typedef struct packed {
    axi_addr_t addr;
  } axi_ar_t;

  typedef struct packed {
    axi_data_t data;
    axi_resp_t resp;
  } axi_r_t;

  typedef struct packed {
    axi_addr_t addr;
  } axi_aw_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } axi_w_t;

  typedef struct packed {
    axi_resp_t resp;
  } axi_b_t;

endpackage

`default_nettype wire

//--- src/ifu.sv
`timescale 1ns/1ns
`default_nettype none

module ifu
  import core_pkg::*, axi_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  output fetch_t  inst,
  output logic    inst_valid,
  input  logic    inst_ready,
  input  logic    redirect_en,
  input  addr_t   redirect_pc,
  output axi_ar_t ar,
  output logic    ar_valid,
  input  logic    ar_ready,
  input  axi_r_t  r,
  input  logic    r_valid,
  output logic    r_ready
);

  typedef enum logic [1:0] {
    F_REQ,
    F_WAIT,
    F_HOLD
  } fetch_state_e;

  fetch_state_e state;
  addr_t        pc;
  addr_t        next_pc;
  inst_t        inst_q;
  logic         fault_q;

  assign next_pc = redirect_en ? redirect_pc : pc + 32'd4;
  assign ar      = '{addr: pc};
  assign r_ready = (state == F_WAIT);
  assign inst    = '{pc: pc, inst: inst_q, fault: fault_q};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= F_REQ;
      pc         <= RESET_PC;
      ar_valid   <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      case (state)
        F_REQ: begin
          if (!ar_valid) begin
            ar_valid <= 1'b1; // first fetch out of reset
          end else if (ar_ready) begin
            ar_valid <= 1'b0;
            state    <= F_WAIT;
          end
        end
        F_WAIT: begin
          if (r_valid) begin
            inst_valid <= 1'b1;
            state      <= F_HOLD;
          end
        end
        F_HOLD: begin
          if (inst_ready) begin // pc moves only on accept
            inst_valid <= 1'b0;
            ar_valid   <= 1'b1;
            pc         <= next_pc;
            state      <= F_REQ;
          end
        end
        default: state <= F_REQ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (r_valid && r_ready) begin
      inst_q  <= r.data;
      fault_q <= (r.resp != RESP_OKAY);
    end
  end

endmodule

`default_nettype wire

//--- src/lsu.sv
`timescale 1ns/1ns
`default_nettype none

module lsu
  import core_pkg::*, axi_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  lsu_req_t  req,
  input  logic      req_valid,
  output logic      req_ready,
  output lsu_resp_t resp,
  output logic      resp_valid,
  input  logic      resp_ready,
  output axi_ar_t   ar,
  output logic      ar_valid,
  input  logic      ar_ready,
  input  axi_r_t    r,
  input  logic      r_valid,
  output logic      r_ready,
  output axi_aw_t   aw,
  output logic      aw_valid,
  input  logic      aw_ready,
  output axi_w_t    w,
  output logic      w_valid,
  input  logic      w_ready,
  input  axi_b_t    b,
  input  logic      b_valid,
  output logic      b_ready
);

  typedef enum logic [1:0] {
    L_IDLE,
    L_READ,
    L_WRITE,
    L_RESP
  } lsu_state_e;

  lsu_state_e state;
  lsu_req_t   req_q;
  logic [1:0] lane;
  axi_addr_t  bus_addr;
  axi_strb_t  w_strb;
  word_t      rd_shift;
  word_t      load_data;

  assign lane     = req_q.addr[1:0];
  assign bus_addr = {req_q.addr[31:2], 2'b00}; // word aligned on the bus
  assign ar       = '{addr: bus_addr};
  assign aw       = '{addr: bus_addr};
  assign w        = '{data: req_q.wdata << {lane, 3'b000}, strb: w_strb};

  // r only after ar is gone, b only after both aw and w
  assign r_ready = (state == L_READ) && !ar_valid;
  assign b_ready = (state == L_WRITE) && !aw_valid && !w_valid;

  always_comb begin
    case (req_q.size)
      SIZE_BYTE: w_strb = 4'b0001 << lane;
      SIZE_HALF: w_strb = 4'b0011 << lane;
      default:   w_strb = 4'b1111;
    endcase
  end

  always_comb begin
    rd_shift = r.data >> {lane, 3'b000};
    case (req_q.size)
      SIZE_BYTE: load_data = {{24{req_q.is_signed & rd_shift[7]}}, rd_shift[7:0]};
      SIZE_HALF: load_data = {{16{req_q.is_signed & rd_shift[15]}}, rd_shift[15:0]};
      default:   load_data = rd_shift;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= L_IDLE;
      req_ready  <= 1'b0;
      ar_valid   <= 1'b0;
      aw_valid   <= 1'b0;
      w_valid    <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      case (state)
        L_IDLE: begin
          if (req_valid && req_ready) begin
            req_ready <= 1'b0;
            if (req.wen) begin
              aw_valid <= 1'b1;
              w_valid  <= 1'b1;
              state    <= L_WRITE;
            end else begin
              ar_valid <= 1'b1;
              state    <= L_READ;
            end
          end else begin
            req_ready <= 1'b1;
          end
        end
        L_READ: begin
          if (ar_ready) ar_valid <= 1'b0;
          if (r_valid && r_ready) begin
            resp_valid <= 1'b1;
            state      <= L_RESP;
          end
        end
        L_WRITE: begin
          if (aw_ready) aw_valid <= 1'b0; // aw and w complete independently
          if (w_ready) w_valid <= 1'b0;
          if (b_valid && b_ready) begin
            resp_valid <= 1'b1;
            state      <= L_RESP;
          end
        end
        L_RESP: begin
          if (resp_ready) begin
            resp_valid <= 1'b0;
            req_ready  <= 1'b1;
            state      <= L_IDLE;
          end
        end
        default: state <= L_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) req_q <= req;
    if (r_valid && r_ready) begin
      resp <= '{rdata: load_data, err: (r.resp != RESP_OKAY)};
    end else if (b_valid && b_ready) begin
      resp <= '{rdata: '0, err: (b.resp != RESP_OKAY)};
    end
  end

endmodule

`default_nettype wire

//--- src/arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module arbiter
  import axi_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  axi_ar_t f_ar,
  input  logic    f_ar_valid,
  output logic    f_ar_ready,
  output axi_r_t  f_r,
  output logic    f_r_valid,
  input  logic    f_r_ready,
  input  axi_ar_t d_ar,
  input  logic    d_ar_valid,
  output logic    d_ar_ready,
  output axi_r_t  d_r,
  output logic    d_r_valid,
  input  logic    d_r_ready,
  input  axi_aw_t d_aw,
  input  logic    d_aw_valid,
  output logic    d_aw_ready,
  input  axi_w_t  d_w,
  input  logic    d_w_valid,
  output logic    d_w_ready,
  output axi_b_t  d_b,
  output logic    d_b_valid,
  input  logic    d_b_ready,
  output axi_ar_t m_ar,
  output logic    m_ar_valid,
  input  logic    m_ar_ready,
  input  axi_r_t  m_r,
  input  logic    m_r_valid,
  output logic    m_r_ready,
  output axi_aw_t m_aw,
  output logic    m_aw_valid,
  input  logic    m_aw_ready,
  output axi_w_t  m_w,
  output logic    m_w_valid,
  input  logic    m_w_ready,
  input  axi_b_t  m_b,
  input  logic    m_b_valid,
  output logic    m_b_ready
);

  typedef enum logic [1:0] {
    G_IDLE,
    G_FETCH,
    G_DATA
  } grant_e;

  grant_e grant;
  logic   g_fetch;
  logic   g_data;
  logic   r_done;
  logic   b_done;

  assign g_fetch = (grant == G_FETCH);
  assign g_data  = (grant == G_DATA);
  assign r_done  = m_r_valid && m_r_ready;
  assign b_done  = m_b_valid && m_b_ready;

  // read address and data go to whichever port holds the grant
  assign m_ar       = g_data ? d_ar : f_ar;
  assign m_ar_valid = (g_fetch && f_ar_valid) || (g_data && d_ar_valid);
  assign f_ar_ready = g_fetch && m_ar_ready;
  assign d_ar_ready = g_data && m_ar_ready;
  assign m_r_ready  = (g_fetch && f_r_ready) || (g_data && d_r_ready);
  assign f_r        = m_r;
  assign f_r_valid  = g_fetch && m_r_valid;
  assign d_r        = m_r;
  assign d_r_valid  = g_data && m_r_valid;

  // write channels belong to the data port only
  assign m_aw       = d_aw;
  assign m_aw_valid = g_data && d_aw_valid;
  assign d_aw_ready = g_data && m_aw_ready;
  assign m_w        = d_w;
  assign m_w_valid  = g_data && d_w_valid;
  assign d_w_ready  = g_data && m_w_ready;
  assign d_b        = m_b;
  assign d_b_valid  = g_data && m_b_valid;
  assign m_b_ready  = g_data && d_b_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant <= G_IDLE;
    end else begin
      case (grant)
        G_IDLE: begin
          if (d_ar_valid || d_aw_valid) grant <= G_DATA; // data port first
          else if (f_ar_valid) grant <= G_FETCH;
        end
        G_FETCH: if (r_done) grant <= G_IDLE;
        G_DATA:  if (r_done || b_done) grant <= G_IDLE;
        default: grant <= G_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/core_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_mem_top
  import core_pkg::*, axi_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  output fetch_t    inst,
  output logic      inst_valid,
  input  logic      inst_ready,
  input  logic      redirect_en,
  input  addr_t     redirect_pc,
  input  lsu_req_t  lsu_req,
  input  logic      req_valid,
  output logic      req_ready,
  output lsu_resp_t lsu_resp,
  output logic      resp_valid,
  input  logic      resp_ready,
  output axi_ar_t   ar,
  output logic      ar_valid,
  input  logic      ar_ready,
  input  axi_r_t    r,
  input  logic      r_valid,
  output logic      r_ready,
  output axi_aw_t   aw,
  output logic      aw_valid,
  input  logic      aw_ready,
  output axi_w_t    w,
  output logic      w_valid,
  input  logic      w_ready,
  input  axi_b_t    b,
  input  logic      b_valid,
  output logic      b_ready
);

  // fetch port
  axi_ar_t f_ar;
  logic    f_ar_valid;
  logic    f_ar_ready;
  axi_r_t  f_r;
  logic    f_r_valid;
  logic    f_r_ready;

  // data port
  axi_ar_t d_ar;
  logic    d_ar_valid;
  logic    d_ar_ready;
  axi_r_t  d_r;
  logic    d_r_valid;
  logic    d_r_ready;
  axi_aw_t d_aw;
  logic    d_aw_valid;
  logic    d_aw_ready;
  axi_w_t  d_w;
  logic    d_w_valid;
  logic    d_w_ready;
  axi_b_t  d_b;
  logic    d_b_valid;
  logic    d_b_ready;

  ifu u_ifu (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst        (inst),
    .inst_valid  (inst_valid),
    .inst_ready  (inst_ready),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .ar          (f_ar),
    .ar_valid    (f_ar_valid),
    .ar_ready    (f_ar_ready),
    .r           (f_r),
    .r_valid     (f_r_valid),
    .r_ready     (f_r_ready)
  );

  lsu u_lsu (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (lsu_req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (lsu_resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .ar         (d_ar),
    .ar_valid   (d_ar_valid),
    .ar_ready   (d_ar_ready),
    .r          (d_r),
    .r_valid    (d_r_valid),
    .r_ready    (d_r_ready),
    .aw         (d_aw),
    .aw_valid   (d_aw_valid),
    .aw_ready   (d_aw_ready),
    .w          (d_w),
    .w_valid    (d_w_valid),
    .w_ready    (d_w_ready),
    .b          (d_b),
    .b_valid    (d_b_valid),
    .b_ready    (d_b_ready)
  );

  arbiter u_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .f_ar       (f_ar),
    .f_ar_valid (f_ar_valid),
    .f_ar_ready (f_ar_ready),
    .f_r        (f_r),
    .f_r_valid  (f_r_valid),
    .f_r_ready  (f_r_ready),
    .d_ar       (d_ar),
    .d_ar_valid (d_ar_valid),
    .d_ar_ready (d_ar_ready),
    .d_r        (d_r),
    .d_r_valid  (d_r_valid),
    .d_r_ready  (d_r_ready),
    .d_aw       (d_aw),
    .d_aw_valid (d_aw_valid),
    .d_aw_ready (d_aw_ready),
    .d_w        (d_w),
    .d_w_valid  (d_w_valid),
    .d_w_ready  (d_w_ready),
    .d_b        (d_b),
    .d_b_valid  (d_b_valid),
    .d_b_ready  (d_b_ready),
    .m_ar       (ar),
    .m_ar_valid (ar_valid),
    .m_ar_ready (ar_ready),
    .m_r        (r),
    .m_r_valid  (r_valid),
    .m_r_ready  (r_ready),
    .m_aw       (aw),
    .m_aw_valid (aw_valid),
    .m_aw_ready (aw_ready),
    .m_w        (w),
    .m_w_valid  (w_valid),
    .m_w_ready  (w_ready),
    .m_b        (b),
    .m_b_valid  (b_valid),
    .m_b_ready  (b_ready)
  );

endmodule

`default_nettype wire

//--- tests/tb_core_mem_assert.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core_mem_assert (
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic        valid,
  input wire logic        ready,
  input wire logic [64:0] payload,
  input wire logic        busy_a,
  input wire logic        busy_b
);

  // a waiting transfer keeps valid and payload
  a_hold_payload: assert property (@(posedge clk) disable iff (!rst_n)
    valid && !ready |=> valid && $stable(payload))
    else $error("payload or valid changed before ready");

  a_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(busy_a && busy_b))
    else $error("two exclusive activities overlapped");

endmodule

bind arbiter tb_core_mem_assert arb_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .valid   (m_ar_valid),
  .ready   (m_ar_ready),
  .payload ({33'b0, m_ar}),
  .busy_a  (f_r_ready || f_ar_ready), // fetch waiting on or sending its read
  .busy_b  (d_r_ready || d_b_ready || d_ar_ready || d_aw_ready)
);

bind ifu tb_core_mem_assert ifu_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .valid   (inst_valid),
  .ready   (inst_ready),
  .payload (inst),
  .busy_a  (ar_valid), // no new fetch while an inst is held
  .busy_b  (inst_valid)
);

`default_nettype wire

//--- tests/tb_core_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core_mem
  import core_pkg::*, axi_pkg::*;
();

  localparam addr_t MEM_BASE       = 32'h8000_0000;
  localparam addr_t DATA_BASE      = 32'h8000_0800; // kept away from fetched code
  localparam addr_t JUMP_PC        = 32'h8000_0140;
  localparam addr_t BAD_ADDR       = 32'h9000_0000;
  localparam int    TIMEOUT_CYCLES = 40 * 12 + 16;

  logic      clk = 1'b0;
  logic      rst_n;
  fetch_t    inst;
  logic      inst_valid;
  logic      inst_ready;
  logic      redirect_en;
  addr_t     redirect_pc;
  lsu_req_t  lsu_req;
  logic      req_valid;
  logic      req_ready;
  lsu_resp_t lsu_resp;
  logic      resp_valid;
  logic      resp_ready;
  axi_ar_t   ar;
  logic      ar_valid;
  logic      ar_ready;
  axi_r_t    r;
  logic      r_valid;
  logic      r_ready;
  axi_aw_t   aw;
  logic      aw_valid;
  logic      aw_ready;
  axi_w_t    w;
  logic      w_valid;
  logic      w_ready;
  axi_b_t    b;
  logic      b_valid;
  logic      b_ready;

  word_t       mem [0:1023];
  word_t       shadow [0:1023]; // expected contents
  logic [31:0] lcg_state = 32'd89677;
  int          cycle_count = 0;
  addr_t       exp_pc;
  logic [10:0] i;

  core_mem_top core_mem_top_inst (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic in_range(addr_t a);
    return a[31:12] == MEM_BASE[31:12];
  endfunction

  function automatic logic [9:0] word_index(addr_t a);
    return a[11:2];
  endfunction

  function automatic fetch_t expect_fetch(addr_t pc);
    if (in_range(pc)) return '{pc: pc, inst: shadow[word_index(pc)], fault: 1'b0};
    return '{pc: pc, inst: '0, fault: 1'b1};
  endfunction

  // byte lane replacement on the expected copy
  function automatic void shadow_store(addr_t a, word_t v, mem_size_t sz);
    logic [4:0] sh;
    sh = {a[1:0], 3'b000};
    case (sz)
      SIZE_BYTE: shadow[word_index(a)][sh +: 8] = v[7:0];
      SIZE_HALF: shadow[word_index(a)][sh +: 16] = v[15:0];
      default:   shadow[word_index(a)] = v;
    endcase
  endfunction

  function automatic word_t expect_load(addr_t a, mem_size_t sz, logic sgn);
    word_t      wv;
    logic [4:0] sh;
    logic [7:0] bv;
    logic [15:0] hv;
    wv = shadow[word_index(a)];
    sh = {a[1:0], 3'b000};
    bv = wv[sh +: 8];
    hv = wv[sh +: 16];
    case (sz)
      SIZE_BYTE: return {{24{sgn & bv[7]}}, bv};
      SIZE_HALF: return {{16{sgn & hv[15]}}, hv};
      default:   return wv;
    endcase
  endfunction

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_fetch(input fetch_t got, input fetch_t exp, input string what);
    if (got !== exp) begin
      $display("ERR t=%0t %s: got pc=%h inst=%h fault=%b, exp pc=%h inst=%h fault=%b",
               $time, what, got.pc, got.inst, got.fault, exp.pc, exp.inst, exp.fault);
      abort_run();
    end
  endtask

  task automatic check_resp(input lsu_resp_t got, input lsu_resp_t exp, input string what);
    if (got !== exp) begin
      $display("ERR t=%0t %s: got rdata=%h err=%b, exp rdata=%h err=%b",
               $time, what, got.rdata, got.err, exp.rdata, exp.err);
      abort_run();
    end
  endtask

  // memory side, one transaction at a time
  task automatic serve_read();
    axi_addr_t   a;
    logic [31:0] d;
    a = ar.addr;
    if (a[1:0] != 2'b00) begin
      $display("ERR t=%0t read address %h not word aligned", $time, a);
      abort_run();
    end
    d = next_rand() >> 30;
    repeat (d) @(negedge clk);
    ar_ready = 1'b1;
    @(negedge clk);
    ar_ready = 1'b0;
    if (in_range(a)) r = '{data: mem[word_index(a)], resp: RESP_OKAY};
    else r = '{data: '0, resp: RESP_SLVERR};
    r_valid = 1'b1;
    while (!r_ready) @(negedge clk);
    @(negedge clk);
    r_valid = 1'b0;
  endtask

  task automatic serve_write();
    axi_addr_t   a;
    axi_w_t      wd;
    logic [31:0] d;
    logic [2:0]  k;
    a = aw.addr;
    wd = w;
    if (a[1:0] != 2'b00) begin
      $display("ERR t=%0t write address %h not word aligned", $time, a);
      abort_run();
    end
    d = next_rand() >> 30;
    repeat (d) @(negedge clk);
    aw_ready = 1'b1;
    w_ready = 1'b1;
    @(negedge clk);
    aw_ready = 1'b0;
    w_ready = 1'b0;
    if (in_range(a)) begin
      for (k = 3'd0; k < 3'd4; k++) begin
        if (wd.strb[k[1:0]]) mem[word_index(a)][{k[1:0], 3'b000} +: 8] =
          wd.data[{k[1:0], 3'b000} +: 8];
      end
    end
    b = '{resp: in_range(a) ? RESP_OKAY : RESP_SLVERR};
    b_valid = 1'b1;
    while (!b_ready) @(negedge clk);
    @(negedge clk);
    b_valid = 1'b0;
  endtask

  initial begin
    ar_ready = 1'b0;
    r = '0;
    r_valid = 1'b0;
    aw_ready = 1'b0;
    w_ready = 1'b0;
    b = '0;
    b_valid = 1'b0;
    forever begin
      @(negedge clk);
      if (ar_valid) serve_read();
      else if (aw_valid && w_valid) serve_write();
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  task automatic take_inst(input logic redir, input addr_t target);
    while (!inst_valid) @(negedge clk);
    check_fetch(inst, expect_fetch(exp_pc), "fetch");
    inst_ready = 1'b1;
    redirect_en = redir;
    redirect_pc = target;
    @(negedge clk);
    inst_ready = 1'b0;
    redirect_en = 1'b0;
    exp_pc = redir ? target : exp_pc + 32'd4;
  endtask

  task automatic lsu_xfer(input lsu_req_t rq, output lsu_resp_t got);
    lsu_req = rq;
    req_valid = 1'b1;
    while (!req_ready) @(negedge clk);
    @(negedge clk);
    req_valid = 1'b0;
    while (!resp_valid) @(negedge clk);
    got = lsu_resp;
    resp_ready = 1'b1;
    @(negedge clk);
    resp_ready = 1'b0;
  endtask

  task automatic store_and_check(input addr_t a, input word_t v, input mem_size_t sz);
    lsu_resp_t got;
    lsu_resp_t exp;
    lsu_xfer('{addr: a, wdata: v, size: sz, is_signed: 1'b0, wen: 1'b1}, got);
    exp = '{rdata: '0, err: !in_range(a)};
    check_resp(got, exp, "store");
    if (in_range(a)) shadow_store(a, v, sz);
  endtask

  task automatic load_and_check(input addr_t a, input mem_size_t sz, input logic sgn);
    lsu_resp_t got;
    lsu_resp_t exp;
    lsu_xfer('{addr: a, wdata: '0, size: sz, is_signed: sgn, wen: 1'b0}, got);
    if (in_range(a)) exp = '{rdata: expect_load(a, sz, sgn), err: 1'b0};
    else exp = '{rdata: '0, err: 1'b1};
    check_resp(got, exp, "load");
  endtask

  task automatic fetch_in_order();
    repeat (5) take_inst(1'b0, '0);
  endtask

  task automatic redirect_under_stall();
    fetch_t      held;
    logic [31:0] n;
    while (!inst_valid) @(negedge clk);
    held = expect_fetch(exp_pc);
    n = 32'd2 + (next_rand() >> 30);
    repeat (n) begin
      @(negedge clk);
      if (!inst_valid) begin
        $display("inst_valid dropped while inst_ready was low");
        abort_run();
      end
      check_fetch(inst, held, "held inst");
    end
    take_inst(1'b1, JUMP_PC);
    take_inst(1'b0, '0);
    take_inst(1'b0, '0);
  endtask

  task automatic store_load_lanes();
    int unsigned lane;
    for (lane = 0; lane < 4; lane++) begin
      store_and_check(DATA_BASE + lane, next_rand() | 32'h0000_8080, SIZE_BYTE);
      load_and_check(DATA_BASE + lane, SIZE_BYTE, lane[0] == 1'b0); // signed on even lanes
    end
    load_and_check(DATA_BASE, SIZE_WORD, 1'b0);
    load_and_check(DATA_BASE, SIZE_HALF, 1'b0);
    for (lane = 0; lane < 4; lane += 2) begin
      store_and_check(DATA_BASE + 32'h4 + lane, next_rand() | 32'h0000_8080, SIZE_HALF);
      load_and_check(DATA_BASE + 32'h4 + lane, SIZE_HALF, lane == 0);
    end
    load_and_check(DATA_BASE + 32'h4, SIZE_WORD, 1'b0);
    store_and_check(DATA_BASE + 32'h8, next_rand(), SIZE_WORD);
    load_and_check(DATA_BASE + 32'h8, SIZE_WORD, 1'b0);
  endtask

  task automatic mixed_traffic();
    int unsigned k;
    fork
      repeat (4) take_inst(1'b0, '0);
      for (k = 0; k < 4; k++) load_and_check(DATA_BASE + 32'h10 + (k << 2), SIZE_WORD, 1'b0);
    join
  endtask

  task automatic bus_error_recovery();
    load_and_check(BAD_ADDR, SIZE_WORD, 1'b0);
    store_and_check(BAD_ADDR + 32'h4, 32'h1234_5678, SIZE_WORD);
    take_inst(1'b1, BAD_ADDR);
    take_inst(1'b1, RESET_PC + 32'h40); // faulted inst, back into range
    take_inst(1'b0, '0);
    load_and_check(DATA_BASE, SIZE_WORD, 1'b0);
  endtask

  initial begin
    rst_n = 1'b0;
    inst_ready = 1'b0;
    redirect_en = 1'b0;
    redirect_pc = '0;
    lsu_req = '0;
    req_valid = 1'b0;
    resp_ready = 1'b0;
    exp_pc = RESET_PC;
    for (i = 11'd0; i < 11'd1024; i++) begin
      mem[i[9:0]] = next_rand() ^ (MEM_BASE + {20'b0, i[9:0], 2'b00});
      shadow[i[9:0]] = mem[i[9:0]];
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    fetch_in_order();
    redirect_under_stall();
    store_load_lanes();
    mixed_traffic();
    bus_error_recovery();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
src/core_pkg.sv
src/axi_pkg.sv
src/ifu.sv
src/lsu.sv
src/arbiter.sv
src/core_mem_top.sv
tests/tb_core_mem_assert.sv
tests/tb_core_mem.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the fail line in the log
rm -f sim.log
verilator --binary --assert --top-module tb_core_mem -f build.f -o Vtb_core_mem \
  && ./obj_dir/Vtb_core_mem > sim.log 2>&1 \
  || echo "** FAIL **" >> sim.log
cat sim.log
grep -q "\*\* FAIL \*\*" sim.log && exit 1 || exit 0
